//--- rtl/tu_gemm_pkg.sv
package tu_gemm_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // operand element, signed
   localparam int elem_width = 8;

   // two full-magnitude products plus sign
   localparam int result_width = 17;

   // square matrix size
   localparam int mat_dim = 2;

   //////////////////////////////
   // element and matrix types
   //////////////////////////////

   typedef logic signed [elem_width-1:0] elem_t;

   typedef logic signed [result_width-1:0] result_t;

   // one port word, read as flat bits or as m[row][col]
   // element 2*row+col lands in byte 2*row+col
   typedef union packed {
      logic [mat_dim*mat_dim*elem_width-1:0] flat;
      elem_t [mat_dim-1:0][mat_dim-1:0]      m;
   } mat2_u;

   // result matrix, row-major, [row][col]
   typedef result_t [mat_dim-1:0][mat_dim-1:0] result_mat_t;

   //////////////////////////////
   // pipeline payloads
   //////////////////////////////

   // one lane job, multiplicand and multiplier
   typedef struct packed {
      elem_t a;
      elem_t b;
   } lane_op_t;

   // both lane jobs for one output position
   typedef struct packed {
      lane_op_t   op0;
      lane_op_t   op1;
      logic [1:0] pos;
   } issue_t;

   // lane product tagged with its position
   typedef struct packed {
      result_t    product;
      logic [1:0] pos;
   } lane_res_t;

endpackage

//--- rtl/operand_sequencer.sv
module operand_sequencer (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  tu_gemm_pkg::mat2_u mat_a,
   input  tu_gemm_pkg::mat2_u mat_b,
   input  logic [1:0]         lane_ready,
   input  logic               all_done,
   output logic               issue_valid,
   output tu_gemm_pkg::issue_t issue,
   output logic               busy
);
   import tu_gemm_pkg::*;

   typedef enum logic [1:0] {
      seq_idle,
      seq_issue,
      seq_drain
   } seq_state_t;

   seq_state_t state;

   // operands held for the whole operation
   mat2_u a_q;
   mat2_u b_q;

   // output position, row-major (r, c)
   logic [1:0] pos_cnt;
   logic       row;
   logic       col;

   assign row = pos_cnt[1];
   assign col = pos_cnt[0];

   //////////////////////////////
   // issue path
   //////////////////////////////

   // both lanes idle, or both just finished this cycle
   assign issue_valid = (state == seq_issue) && (&lane_ready);

   // busy from capture until accumulator signals the last write
   assign busy = (state != seq_idle);

   // lane 0 takes the k=0 term, lane 1 the k=1 term
   always_comb begin
      issue.op0.a = a_q.m[row][0];
      issue.op0.b = b_q.m[0][col];
      issue.op1.a = a_q.m[row][1];
      issue.op1.b = b_q.m[1][col];
      issue.pos   = pos_cnt;
   end

   //////////////////////////////
   // control
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= seq_idle;
         pos_cnt <= 2'd0;
      end else begin
         case (state)
            seq_idle: begin
               // start outside idle is dropped
               if (start) begin
                  state   <= seq_issue;
                  pos_cnt <= 2'd0;
               end
            end
            seq_issue: begin
               if (issue_valid) begin
                  pos_cnt <= pos_cnt + 2'd1;
                  // fourth position out, wait for the sums
                  if (pos_cnt == 2'd3) begin
                     state <= seq_drain;
                  end
               end
            end
            seq_drain: begin
               if (all_done) begin
                  state <= seq_idle;
               end
            end
            default: state <= seq_idle;
         endcase
      end
   end

   // operand capture on an accepted start
   always_ff @(posedge clk) begin
      if (state == seq_idle && start) begin
         a_q <= mat_a;
         b_q <= mat_b;
      end
   end

endmodule

//--- rtl/unary_multiplier.sv
module unary_multiplier #(
   parameter int elem_width   = tu_gemm_pkg::elem_width,
   parameter int result_width = tu_gemm_pkg::result_width
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   issue_valid,
   input  tu_gemm_pkg::lane_op_t  op,
   input  logic [1:0]             pos,
   output logic                   ready,
   output logic                   prod_valid,
   output tu_gemm_pkg::lane_res_t res
);
   import tu_gemm_pkg::*;

   // one extra bit so -128 has a magnitude
   localparam int cnt_width = elem_width + 1;

   typedef enum logic [1:0] {
      st_idle,
      st_load,
      st_count_a,
      st_count_b
   } state_t;

   state_t state;

   lane_op_t   op_q;
   logic [1:0] pos_q;

   // signed counters, walked toward zero
   logic signed [cnt_width-1:0] count_a;
   logic signed [cnt_width-1:0] count_b;
   logic signed [cnt_width-1:0] a_ext;
   logic signed [cnt_width-1:0] b_ext;
   logic signed [cnt_width-1:0] a_next;
   logic signed [cnt_width-1:0] b_next;

   // operand sign flags
   logic neg_a;
   logic neg_b;

   // running product, one unit step per count cycle
   logic signed [result_width-1:0] product;

   assign a_ext = {op_q.a[elem_width-1], op_q.a};
   assign b_ext = {op_q.b[elem_width-1], op_q.b};

   // step direction from the counter's own sign
   assign a_next = count_a[cnt_width-1] ? count_a + 1'b1 : count_a - 1'b1;
   assign b_next = count_b[cnt_width-1] ? count_b + 1'b1 : count_b - 1'b1;

   assign ready       = (state == st_idle);
   assign res.product = product;
   assign res.pos     = pos_q;

   //////////////////////////////
   // state machine
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_idle;
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (issue_valid) begin
                  state <= st_load;
               end
            end
            st_load: begin
               // zero operand, nothing to count
               if (op_q.a == '0 || op_q.b == '0) begin
                  prod_valid <= 1'b1;
                  state      <= st_idle;
               end else begin
                  state <= st_count_a;
               end
            end
            // one step of a per pass
            st_count_a: state <= st_count_b;
            st_count_b: begin
               // last unit of b in this pass
               if (b_next == '0) begin
                  if (count_a == '0) begin
                     prod_valid <= 1'b1;
                     state      <= st_idle;
                  end else begin
                     state <= st_count_a;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   //////////////////////////////
   // counters and product
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (state == st_idle && issue_valid) begin
         op_q  <= op;
         pos_q <= pos;
      end
      case (state)
         st_load: begin
            count_a <= a_ext;
            neg_a   <= op_q.a[elem_width-1];
            neg_b   <= op_q.b[elem_width-1];
            product <= '0;
         end
         st_count_a: begin
            count_a <= a_next;
            // b reloaded for every unit of a
            count_b <= b_ext;
         end
         st_count_b: begin
            count_b <= b_next;
            // signs differ, count down
            product <= (neg_a ^ neg_b) ? product - 1'b1 : product + 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- rtl/result_accumulator.sv
module result_accumulator (
   input  logic                     clk,
   input  logic                     rst,
   input  tu_gemm_pkg::lane_res_t   res0,
   input  logic                     valid0,
   input  tu_gemm_pkg::lane_res_t   res1,
   input  logic                     valid1,
   output tu_gemm_pkg::result_mat_t result,
   output logic                     all_done,
   output logic                     done
);
   import tu_gemm_pkg::*;

   // products waiting for their partner lane
   lane_res_t hold0;
   lane_res_t hold1;
   logic      pend0;
   logic      pend1;

   logic    write_en;
   result_t sum;
   logic    done_q;

   // both terms of one position present
   assign write_en = pend0 & pend1;
   assign sum      = hold0.product + hold1.product;

   // port pulse and sequencer release share one flop
   assign done     = done_q;
   assign all_done = done_q;

   //////////////////////////////
   // pending flags and result
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         pend0  <= 1'b0;
         pend1  <= 1'b0;
         done_q <= 1'b0;
         result <= '0;
      end else begin
         // last position written, results complete next cycle
         done_q <= write_en && (hold0.pos == 2'd3);
         if (write_en) begin
            result[hold0.pos[1]][hold0.pos[0]] <= sum;
            pend0 <= 1'b0;
            pend1 <= 1'b0;
         end
         // a new strobe wins over the clear
         if (valid0) begin
            pend0 <= 1'b1;
         end
         if (valid1) begin
            pend1 <= 1'b1;
         end
      end
   end

   // lane products latched on their strobes
   always_ff @(posedge clk) begin
      if (valid0) begin
         hold0 <= res0;
      end
      if (valid1) begin
         hold1 <= res1;
      end
   end

endmodule

//--- rtl/tu_gemm.sv
module tu_gemm #(
   parameter int elem_width   = tu_gemm_pkg::elem_width,
   parameter int result_width = tu_gemm_pkg::result_width
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  tu_gemm_pkg::mat2_u       mat_a,
   input  tu_gemm_pkg::mat2_u       mat_b,
   output logic                     done,
   output logic                     busy,
   output tu_gemm_pkg::result_mat_t result
);
   import tu_gemm_pkg::*;

   // sequencer to lanes
   issue_t     issue;
   logic       issue_valid;
   logic [1:0] lane_ready;

   // lanes to accumulator
   lane_res_t res0;
   lane_res_t res1;
   logic      valid0;
   logic      valid1;

   // accumulator back to sequencer
   logic all_done;

   //////////////////////////////
   // stage 1, position walk
   //////////////////////////////

   operand_sequencer sequencer_inst (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .mat_a       (mat_a),
      .mat_b       (mat_b),
      .lane_ready  (lane_ready),
      .all_done    (all_done),
      .issue_valid (issue_valid),
      .issue       (issue),
      .busy        (busy)
   );

   //////////////////////////////
   // stage 2, counting lanes
   //////////////////////////////

   // k=0 term
   unary_multiplier #(
      .elem_width   (elem_width),
      .result_width (result_width)
   ) lane0 (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .op          (issue.op0),
      .pos         (issue.pos),
      .ready       (lane_ready[0]),
      .prod_valid  (valid0),
      .res         (res0)
   );

   // k=1 term
   unary_multiplier #(
      .elem_width   (elem_width),
      .result_width (result_width)
   ) lane1 (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .op          (issue.op1),
      .pos         (issue.pos),
      .ready       (lane_ready[1]),
      .prod_valid  (valid1),
      .res         (res1)
   );

   //////////////////////////////
   // stage 3, sum and write
   //////////////////////////////

   result_accumulator accumulator_inst (
      .clk      (clk),
      .rst      (rst),
      .res0     (res0),
      .valid0   (valid0),
      .res1     (res1),
      .valid1   (valid1),
      .result   (result),
      .all_done (all_done),
      .done     (done)
   );

endmodule

//--- verification/tu_gemm_sva.sv
module tu_gemm_sva (
   input logic clk,
   input logic rst,
   input logic start,
   input logic done,
   input logic busy
);

   // armed by an accepted start and cleared by its done
   logic start_seen;

   always_ff @(posedge clk) begin
      if (rst) begin
         start_seen <= 1'b0;
      end else if (start && !busy) begin
         start_seen <= 1'b1;
      end else if (done) begin
         start_seen <= 1'b0;
      end
   end

   //////////////////////////////
   // done and busy
   //////////////////////////////

   // done is a one-cycle pulse
   done_single_cycle: assert property (
      @(posedge clk) disable iff (rst) done |=> !done
   ) else $error("done stayed high for more than one cycle");

   // every done has its own accepted start
   done_after_start: assert property (
      @(posedge clk) disable iff (rst) $rose(done) |-> start_seen
   ) else $error("done rose without an accepted start since the last done");

   // sequencer returns to idle right after done
   busy_falls_after_done: assert property (
      @(posedge clk) disable iff (rst) done |=> !busy
   ) else $error("busy still high the cycle after done");

endmodule

bind tu_gemm tu_gemm_sva tu_gemm_sva_inst (
   .clk   (clk),
   .rst   (rst),
   .start (start),
   .done  (done),
   .busy  (busy)
);

//--- verification/tb_tu_gemm.sv
module tb_tu_gemm;
   import tu_gemm_pkg::*;

   localparam int clk_period = 8;
   // worst lane job: issue, load, 128 passes of one step plus 128 counts
   localparam int lane_worst = 2 + 128 * 129 + 4;
   localparam int op_worst   = 4 * lane_worst + 8;
   // identity 2, zeros 3, extremes 2, random 8, start while busy 1
   localparam int op_total   = 16;
   // start-while-busy window and reset on top of the operations
   localparam int watchdog_time = (op_total + 2) * op_worst * clk_period;

   logic        clk;
   logic        rst;
   logic        start;
   mat2_u       mat_a;
   mat2_u       mat_b;
   logic        done;
   logic        busy;
   result_mat_t result;

   int     error_count;
   int     check_count;
   integer seed;

   tu_gemm #(
      .elem_width   (elem_width),
      .result_width (result_width)
   ) tu_gemm_inst (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .mat_a  (mat_a),
      .mat_b  (mat_b),
      .done   (done),
      .busy   (busy),
      .result (result)
   );

   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////
   // helpers
   //////////////////////////////

   // matrix from four elements, row-major
   function automatic mat2_u make_mat(input int e00, input int e01,
                                      input int e10, input int e11);
      mat2_u m;
      m.m[0][0] = elem_t'(e00);
      m.m[0][1] = elem_t'(e01);
      m.m[1][0] = elem_t'(e10);
      m.m[1][1] = elem_t'(e11);
      return m;
   endfunction

   // C[r][c] = A[r][0]*B[0][c] + A[r][1]*B[1][c]
   function automatic int model_elem(input mat2_u a, input mat2_u b, input int r, input int c);
      int acc;
      acc = 0;
      for (int k = 0; k < mat_dim; k++) begin
         acc += int'(a.m[r][k]) * int'(b.m[k][c]);
      end
      return acc;
   endfunction

   // all tb activity sits just after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      check_count++;
      assert (actual == expected) else begin
         error_count++;
         $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   // all four results against the model
   task automatic check_results(input string name, input mat2_u a, input mat2_u b);
      for (int r = 0; r < mat_dim; r++) begin
         for (int c = 0; c < mat_dim; c++) begin
            check_value($sformatf("%s C[%0d][%0d]", name, r, c), model_elem(a, b, r, c),
                        int'(result[r][c]));
         end
      end
   endtask

   // a start during the drain cycle is dropped by the sequencer
   task automatic wait_idle();
      while (busy) begin
         next_cycle();
      end
   endtask

   task automatic pulse_start(input mat2_u a, input mat2_u b);
      mat_a = a;
      mat_b = b;
      start = 1'b1;
      next_cycle();
      start = 1'b0;
   endtask

   task automatic wait_done(input string name);
      int cycles;
      cycles = 0;
      while (!done && cycles < op_worst) begin
         next_cycle();
         cycles++;
      end
      check_count++;
      assert (done) else begin
         error_count++;
         $display("%s never raised done within %0d cycles", name, op_worst);
      end
   endtask

   task automatic run_op(input string name, input mat2_u a, input mat2_u b);
      wait_idle();
      pulse_start(a, b);
      wait_done(name);
      check_results(name, a, b);
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////

   task automatic test_reset();
      check_value("reset_done", 0, int'(done));
      check_value("reset_busy", 0, int'(busy));
      check_results("reset", '0, '0);
   endtask

   task automatic test_identity();
      run_op("identity", make_mat(-7, 12, 100, -1), make_mat(1, 0, 0, 1));
      // [3 -2; -5 4] x [6 1; -3 -8] by hand
      run_op("mixed_sign", make_mat(3, -2, -5, 4), make_mat(6, 1, -3, -8));
      check_value("mixed_sign_hand C[0][0]", 24, int'(result[0][0]));
      check_value("mixed_sign_hand C[0][1]", 19, int'(result[0][1]));
      check_value("mixed_sign_hand C[1][0]", -42, int'(result[1][0]));
      check_value("mixed_sign_hand C[1][1]", -37, int'(result[1][1]));
   endtask

   task automatic test_zeros();
      run_op("zero_a_entries", make_mat(0, 5, -9, 0), make_mat(4, -3, 0, 7));
      run_op("zero_b_entries", make_mat(11, -6, 2, 8), make_mat(0, 0, -5, 0));
      // overwrites the previous nonzero results
      run_op("all_zero", make_mat(0, 0, 0, 0), make_mat(9, -9, 127, -128));
   endtask

   task automatic test_extremes();
      run_op("all_min", make_mat(-128, -128, -128, -128), make_mat(-128, -128, -128, -128));
      check_value("all_min_hand", 32768, int'(result[1][1]));
      run_op("min_max_mix", make_mat(-128, 127, 127, -128), make_mat(127, -128, -128, 127));
   endtask

   task automatic test_random();
      mat2_u a;
      mat2_u b;
      for (int i = 0; i < 8; i++) begin
         a.flat = $random(seed);
         b.flat = $random(seed);
         run_op($sformatf("random_%0d", i), a, b);
         // results must hold while idle
         repeat (10) next_cycle();
         check_results($sformatf("random_%0d_hold", i), a, b);
      end
   endtask

   task automatic test_start_busy();
      mat2_u a;
      mat2_u b;
      int    done_count;
      a = make_mat(20, -30, 15, 9);
      b = make_mat(-4, 25, 6, -11);
      done_count = 0;
      wait_idle();
      pulse_start(a, b);
      repeat (5) next_cycle();
      check_value("start_busy_level", 1, int'(busy));
      pulse_start(make_mat(-100, 90, -80, 70), make_mat(60, -50, 40, -30));
      // long enough for a wrongly accepted second operation to finish
      repeat (op_worst) begin
         next_cycle();
         if (done) begin
            done_count++;
         end
      end
      check_value("start_busy_done_count", 1, done_count);
      check_results("start_busy", a, b);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      start = 1'b0;
      mat_a = '0;
      mat_b = '0;
      error_count = 0;
      check_count = 0;
      seed = 32'hbf9759c7;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset();
      test_identity();
      test_zeros();
      test_extremes();
      test_random();
      test_start_busy();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // every operation at its worst case
   initial begin
      #(watchdog_time);
      $display("watchdog expired after %0d time units, simulation stopped", watchdog_time);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- flist.f
rtl/tu_gemm_pkg.sv
rtl/operand_sequencer.sv
rtl/unary_multiplier.sv
rtl/result_accumulator.sv
rtl/tu_gemm.sv
verification/tu_gemm_sva.sv
verification/tb_tu_gemm.sv

//--- Makefile
# tu_gemm simulation with Verilator

TOP := tb_tu_gemm

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless it passes"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

obj_dir/V$(TOP): flist.f $(wildcard rtl/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f flist.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
